// ==== all.f ====
+incdir+include
rtl/fpMulPkg.sv
rtl/operandGather.sv
rtl/fpRoundPack.sv
rtl/fpMulLane.sv
rtl/resultSerializer.sv
rtl/fpVecMul.sv
sim/fpVecMulTb.sv

// ==== include/fpMul_consts.svh ====
`ifndef FPMUL_CONSTS_SVH
`define FPMUL_CONSTS_SVH

// Half precision field layout
`define FP_EXP 5      // Exponent bits
`define FP_FRAC 10    // Stored fraction bits
`define FP_WIDTH 16   // Sign + exponent + fraction

// Exponent bias for 5 exponent bits
`define FP_BIAS 15

// Number of parallel multiplier lanes in one row
`define VEC_LANES 8

// Canonical quiet NaN returned for every invalid operation
// Positive sign, all-ones exponent, top fraction bit set
`define FP_QNAN 16'h7E00

`endif

// ==== rtl/fpMulLane.sv ====
`timescale 1ns/1ps
`include "fpMul_consts.svh"

module fpMulLane (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  fpMulPkg::opPair pair,
	output logic outValid,                // 5 cycles after inValid
	output fpMulPkg::mulResult res
);
	import fpMulPkg::*;

	localparam int MANT_W = `FP_FRAC + 1;   // Significand with hidden one
	localparam int PROD_W = 2 * MANT_W;     // Full product width
	localparam int EXP_W = `FP_EXP + 2;     // Signed exponent, room for over/underflow

	// Prepare -> execute
	typedef struct packed {
		logic sign;
		specialKind kind;
		logic invalid;
		logic [`FP_EXP-1:0] expA;
		logic [`FP_EXP-1:0] expB;
		logic [MANT_W-1:0] mantA;
		logic [MANT_W-1:0] mantB;
	} prepStage;

	// Execute -> normalize
	typedef struct packed {
		logic sign;
		specialKind kind;
		logic invalid;
		logic [`FP_EXP:0] expSum;       // Still carries two biases
		logic [PROD_W-1:0] prod;
	} execStage;

	// Operand classes
	logic aNan;
	logic bNan;
	logic aInf;
	logic bInf;
	logic aZero;
	logic bZero;

	prepStage prepNext;
	execStage execNext;
	roundIn normNext;
	logic [PROD_W-1:0] normProd;      // Product with leading one in the MSB
	logic prodTop;                    // Product in [2,4)

	// Stage registers and their valids
	prepStage s1;
	execStage s2;
	roundIn s3;
	logic v1;
	logic v2;
	logic v3;

	// Stage 1, prepare
	assign aNan = (&pair.a.exp) && (|pair.a.frac);
	assign bNan = (&pair.b.exp) && (|pair.b.frac);
	assign aInf = (&pair.a.exp) && !(|pair.a.frac);
	assign bInf = (&pair.b.exp) && !(|pair.b.frac);
	assign aZero = !(|pair.a.exp);    // Subnormals treated as zero
	assign bZero = !(|pair.b.exp);

	always_comb begin
		prepNext.sign = pair.a.sign ^ pair.b.sign;
		prepNext.invalid = aNan | bNan | (aInf & bZero) | (bInf & aZero);
		// Priority NaN, inf, zero
		if (prepNext.invalid)
			prepNext.kind = kindNan;
		else if (aInf | bInf)
			prepNext.kind = kindInf;
		else if (aZero | bZero)
			prepNext.kind = kindZero;
		else
			prepNext.kind = kindNormal;
		prepNext.expA = pair.a.exp;
		prepNext.expB = pair.b.exp;
		prepNext.mantA = {1'b1, pair.a.frac};   // Hidden bit
		prepNext.mantB = {1'b1, pair.b.frac};
	end

	// Stage 2, execute
	always_comb begin
		execNext.sign = s1.sign;
		execNext.kind = s1.kind;
		execNext.invalid = s1.invalid;
		execNext.expSum = s1.expA + s1.expB;
		execNext.prod = s1.mantA * s1.mantB;   // 11x11 unsigned
	end

	// Stage 3, normalize
	assign prodTop = s2.prod[PROD_W-1];
	// Shift left once when the product is below 2
	assign normProd = prodTop ? s2.prod : {s2.prod[PROD_W-2:0], 1'b0};

	always_comb begin
		normNext.sign = s2.sign;
		normNext.kind = s2.kind;
		normNext.invalid = s2.invalid;
		// Drop one bias, add one when the product carried into bit 21
		normNext.exp = EXP_W'(s2.expSum) - EXP_W'(`FP_BIAS) + EXP_W'(prodTop);
		normNext.mant = normProd[PROD_W-1 -: MANT_W];
		normNext.guard = normProd[PROD_W-1-MANT_W];
		normNext.round = normProd[PROD_W-2-MANT_W];
		normNext.sticky = |normProd[PROD_W-3-MANT_W:0];   // OR of the rest
	end

	// Valid chain, control only
	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= inValid;
			v2 <= v1;
			v3 <= v2;
		end
	end

	// Payload pipeline
	always_ff @(posedge clk) begin
		s1 <= prepNext;
		s2 <= execNext;
		s3 <= normNext;
	end

	// Stages 4 and 5, round and pack
	fpRoundPack roundPack (
		.clk(clk),
		.rst(rst),
		.inValid(v3),
		.rin(s3),
		.outValid(outValid),
		.res(res)
	);

	// Normal operands always give a normalized significand
	assert property (@(posedge clk) disable iff (rst)
		(v3 && s3.kind == kindNormal) |-> s3.mant[MANT_W-1])
		else $error("fpMulLane mantissa lost its leading one");

endmodule

// ==== rtl/fpMulPkg.sv ====
`include "fpMul_consts.svh"

package fpMulPkg;

	// One half precision number, sign in the MSB
	typedef struct packed {
		logic sign;
		logic [`FP_EXP-1:0] exp;
		logic [`FP_FRAC-1:0] frac;
	} fpHalf;

	// Operand pair as it arrives on the input strobe
	typedef struct packed {
		fpHalf a;
		fpHalf b;
	} opPair;

	// Exception flags, one bit each
	typedef struct packed {
		logic invalid;    // NaN in, or inf times zero
		logic infIn;      // Infinity operand, valid result
		logic overflow;   // Rounded result too big
		logic underflow;  // Result flushed to zero
		logic inexact;    // Some product bit was dropped
	} fpFlags;

	// Product plus its flags
	typedef struct packed {
		fpHalf prod;
		fpFlags flags;
	} mulResult;

	// Operand class after the prepare stage
	typedef enum logic [1:0] {
		kindNormal,
		kindZero,
		kindInf,
		kindNan
	} specialKind;

	// Normalize stage to round stage
	typedef struct packed {
		logic sign;
		logic signed [`FP_EXP+1:0] exp;  // Result exponent, one bias removed
		logic [`FP_FRAC:0] mant;         // Leading one in the MSB
		logic guard;
		logic round;
		logic sticky;
		specialKind kind;
		logic invalid;
	} roundIn;

endpackage

// ==== rtl/fpRoundPack.sv ====
`timescale 1ns/1ps
`include "fpMul_consts.svh"

module fpRoundPack (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  fpMulPkg::roundIn rin,
	output logic outValid,
	output fpMulPkg::mulResult res      // Lane output register
);
	import fpMulPkg::*;

	localparam int MANT_W = `FP_FRAC + 1;
	localparam int EXP_W = `FP_EXP + 2;
	localparam int EXP_MAX = (1 << `FP_EXP) - 1;   // All-ones exponent, inf
	localparam logic [`FP_WIDTH-1:0] QNAN = `FP_QNAN;

	// Round -> pack
	typedef struct packed {
		logic sign;
		specialKind kind;
		logic invalid;
		logic signed [EXP_W-1:0] exp;
		logic [`FP_FRAC-1:0] frac;
		logic inexact;
	} roundStage;

	roundStage rndNext;
	roundStage r4;
	logic v4;
	logic roundUp;
	logic [MANT_W:0] mantSum;     // Extra bit catches the rounding carry
	mulResult packNext;

	// Stage 4, nearest-even
	always_comb begin
		roundUp = rin.guard & (rin.round | rin.sticky | rin.mant[0]);   // Ties go to even
		mantSum = {1'b0, rin.mant} + roundUp;
		rndNext.sign = rin.sign;
		rndNext.kind = rin.kind;
		rndNext.invalid = rin.invalid;
		rndNext.inexact = rin.guard | rin.round | rin.sticky;
		if (mantSum[MANT_W]) begin
			rndNext.frac = mantSum[MANT_W-1:1];   // 1.111.. rounded to 10.000..
			rndNext.exp = rin.exp + EXP_W'(1);
		end else begin
			rndNext.frac = mantSum[`FP_FRAC-1:0];
			rndNext.exp = rin.exp;
		end
	end

	// Stage 5, special encodings and range checks
	always_comb begin
		packNext.flags = '0;
		packNext.flags.invalid = r4.invalid;
		packNext.prod.sign = r4.sign;
		packNext.prod.exp = r4.exp[`FP_EXP-1:0];
		packNext.prod.frac = r4.frac;
		case (r4.kind)
			kindNan: packNext.prod = QNAN;   // Sign of the NaN is fixed
			kindInf: begin
				packNext.prod.exp = '1;
				packNext.prod.frac = '0;
				packNext.flags.infIn = 1'b1;
			end
			kindZero: begin
				packNext.prod.exp = '0;   // Signed zero
				packNext.prod.frac = '0;
			end
			default: begin
				packNext.flags.inexact = r4.inexact;
				if (r4.exp >= EXP_MAX) begin
					packNext.prod.exp = '1;   // Saturate to inf
					packNext.prod.frac = '0;
					packNext.flags.overflow = 1'b1;
					packNext.flags.inexact = 1'b1;
				end else if (r4.exp < 1) begin
					packNext.prod.exp = '0;   // Flush to zero
					packNext.prod.frac = '0;
					packNext.flags.underflow = 1'b1;
					packNext.flags.inexact = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			v4 <= 1'b0;
			outValid <= 1'b0;
		end else begin
			v4 <= inValid;
			outValid <= v4;
		end
	end

	always_ff @(posedge clk) begin
		r4 <= rndNext;
		res <= packNext;
	end

endmodule

// ==== rtl/fpVecMul.sv ====
`timescale 1ns/1ps
`include "fpMul_consts.svh"

module fpVecMul (
	input  logic clk,
	input  logic rst,
	input  logic inValid,                 // One pair per strobe
	input  fpMulPkg::opPair inPair,
	output logic outValid,                // 7 cycles after the row's last pair
	output fpMulPkg::mulResult outRes
);
	import fpMulPkg::*;

	// Gather -> lanes
	logic rowValid;
	opPair rowPairs [0:`VEC_LANES-1];

	// Lanes -> serializer
	logic [`VEC_LANES-1:0] laneValid;
	mulResult laneRes [0:`VEC_LANES-1];

	operandGather gather (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inPair(inPair),
		.rowValid(rowValid),
		.rowPairs(rowPairs)
	);

	// Identical lanes, all fed by the same row pulse
	for (genvar i = 0; i < `VEC_LANES; i++) begin : genLane
		fpMulLane lane (
			.clk(clk),
			.rst(rst),
			.inValid(rowValid),
			.pair(rowPairs[i]),
			.outValid(laneValid[i]),
			.res(laneRes[i])
		);
	end

	// Lanes run in lockstep so lane 0 speaks for the row
	resultSerializer serializer (
		.clk(clk),
		.rst(rst),
		.loadValid(laneValid[0]),
		.rowRes(laneRes),
		.outValid(outValid),
		.outRes(outRes)
	);

endmodule

// ==== rtl/operandGather.sv ====
`timescale 1ns/1ps
`include "fpMul_consts.svh"

module operandGather (
	input  logic clk,
	input  logic rst,
	input  logic inValid,                                 // One pair per strobe
	input  fpMulPkg::opPair inPair,
	output logic rowValid,                                // Pulse when a row is full
	output fpMulPkg::opPair rowPairs [0:`VEC_LANES-1]    // Held until overwritten
);

	localparam int SLOT_W = $clog2(`VEC_LANES);
	localparam logic [SLOT_W-1:0] LAST = SLOT_W'(`VEC_LANES - 1);

	logic [SLOT_W-1:0] slot;   // Next slot to write
	logic lastSlot;            // Current strobe completes the row

	assign lastSlot = (slot == LAST);

	// Slot counter and row pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
			rowValid <= 1'b0;
		end else begin
			rowValid <= inValid && lastSlot;   // High the cycle after the last pair
			if (inValid) begin
				if (lastSlot)
					slot <= '0;   // Wrap for next row
				else
					slot <= slot + 1'b1;
			end
		end
	end

	// Row storage
	// Lanes sample the row on the edge after rowValid, so the first
	// pair of the next row can land in slot 0 on that same edge
	always_ff @(posedge clk) begin
		if (inValid)
			rowPairs[slot] <= inPair;
	end

	// Counter stays inside the row
	assert property (@(posedge clk) disable iff (rst)
		slot <= LAST)
		else $error("operandGather slot counter out of range");

endmodule

// ==== rtl/resultSerializer.sv ====
`timescale 1ns/1ps
`include "fpMul_consts.svh"

module resultSerializer (
	input  logic clk,
	input  logic rst,
	input  logic loadValid,                                // Row of lane results ready
	input  fpMulPkg::mulResult rowRes [0:`VEC_LANES-1],
	output logic outValid,
	output fpMulPkg::mulResult outRes                     // One element per cycle
);
	import fpMulPkg::*;

	localparam int IDX_W = $clog2(`VEC_LANES);
	localparam logic [IDX_W-1:0] LAST = IDX_W'(`VEC_LANES - 1);

	mulResult hold [0:`VEC_LANES-1];   // Captured row
	logic [IDX_W-1:0] left;            // Elements after the current one
	logic [IDX_W-1:0] idx;             // Element being presented

	// Element index counts up as left counts down
	assign idx = LAST - left;

	// Capture the whole row on load
	always_ff @(posedge clk) begin
		if (loadValid)
			hold <= rowRes;
	end

	// Drain control
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			left <= '0;
		end else if (loadValid) begin
			outValid <= 1'b1;      // Element 0 next cycle
			left <= LAST;
		end else if (left != '0) begin
			outValid <= 1'b1;
			left <= left - 1'b1;
		end else begin
			outValid <= 1'b0;      // Row done
		end
	end

	// Output mux straight from the holding register
	assign outRes = hold[idx];

	// Without back-pressure a new row must not land mid-drain
	assert property (@(posedge clk) disable iff (rst)
		loadValid |-> (left == '0))
		else $error("resultSerializer loaded while still draining");

endmodule

// ==== sim/fpVecMulTb.sv ====
`timescale 1ns/1ps
`include "fpMul_consts.svh"

module fpVecMulTb;
	import fpMulPkg::*;

	logic clk;
	logic rst;
	logic inValid;
	opPair inPair;
	logic outValid;
	mulResult outRes;

	mulResult expQ [$];        // Expected results in send order
	mulResult expRes;          // Front of queue at each output
	int pairCount = 0;         // Pairs sent so far
	int rowsSent = 0;          // Full rows sent
	int checkedCount = 0;
	int cycles = 0;
	logic [31:0] rngState = 32'd80251;

	fpVecMul DUT (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inPair(inPair),
		.outValid(outValid),
		.outRes(outRes)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compareHalf(input fpHalf got, input fpHalf want, input string what);
		if (got !== want) begin
			$display("mismatch at %0t: %s product %h expected %h", $time, what, got, want);
			stopWithFailure("product check failed");
		end
	endtask

	task automatic compareFlags(input fpFlags got, input fpFlags want, input string what);
		if (got !== want) begin
			$display("mismatch at %0t: %s flags %b expected %b", $time, what, got, want);
			stopWithFailure("flag check failed");
		end
	endtask

	// Reference model on integer significands
	function automatic mulResult modelMul(input opPair p);
		mulResult r;
		logic aNan;
		logic bNan;
		logic aInf;
		logic bInf;
		logic aZero;
		logic bZero;
		logic sgn;
		int prod;
		int e;
		int sh;
		int mant;
		int rem;
		int half;
		r = '0;
		sgn = p.a.sign ^ p.b.sign;
		aNan = (p.a.exp == 5'h1f) && (p.a.frac != 0);
		bNan = (p.b.exp == 5'h1f) && (p.b.frac != 0);
		aInf = (p.a.exp == 5'h1f) && (p.a.frac == 0);
		bInf = (p.b.exp == 5'h1f) && (p.b.frac == 0);
		aZero = (p.a.exp == 0);   // Subnormal counts as zero
		bZero = (p.b.exp == 0);
		if (aNan || bNan || (aInf && bZero) || (bInf && aZero)) begin
			r.prod = `FP_QNAN;
			r.flags.invalid = 1'b1;
		end else if (aInf || bInf) begin
			r.prod = {sgn, 5'h1f, 10'h000};
			r.flags.infIn = 1'b1;
		end else if (aZero || bZero) begin
			r.prod = {sgn, 15'h0000};
		end else begin
			prod = (1024 + int'(p.a.frac)) * (1024 + int'(p.b.frac));
			e = int'(p.a.exp) + int'(p.b.exp) - `FP_BIAS;
			sh = 10;
			if (prod >= (1 << 21)) begin   // Product in [2,4)
				e++;
				sh = 11;
			end
			mant = prod >> sh;
			rem = prod % (1 << sh);
			half = 1 << (sh - 1);
			if (rem > half || (rem == half && (mant % 2) == 1))
				mant++;
			if (mant == 2048) begin   // Round carried out
				mant = 1024;
				e++;
			end
			r.flags.inexact = (rem != 0);
			if (e >= 31) begin
				r.prod = {sgn, 5'h1f, 10'h000};
				r.flags.overflow = 1'b1;
				r.flags.inexact = 1'b1;
			end else if (e < 1) begin
				r.prod = {sgn, 15'h0000};   // Flush to signed zero
				r.flags.underflow = 1'b1;
				r.flags.inexact = 1'b1;
			end else begin
				r.prod = {sgn, e[4:0], mant[9:0]};
			end
		end
		return r;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Mostly mid-range exponents with a quarter raw bit patterns
	function automatic fpHalf randomOperand();
		logic [31:0] r;
		fpHalf h;
		r = nextRand();
		h = r[15:0];
		if (r[31:30] != 2'b00)
			h.exp = 5'd7 + 5'(r[19:16]);
		return h;
	endfunction

	function automatic opPair makePair(input logic [15:0] a, input logic [15:0] b);
		opPair p;
		p.a = a;
		p.b = b;
		return p;
	endfunction

	// Drive on the falling edge and hold one cycle
	task automatic sendPair(input opPair p);
		inValid = 1'b1;
		inPair = p;
		expQ.push_back(modelMul(p));
		pairCount++;
		if (pairCount % `VEC_LANES == 0)
			rowsSent++;
		@(negedge clk);
	endtask

	task automatic idleCycles(input int n);
		inValid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	// Fill the open row with 1.0 x 1.0 so it launches
	task automatic padRow();
		while (pairCount % `VEC_LANES != 0)
			sendPair(makePair(16'h3C00, 16'h3C00));
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic flushTest();
		padRow();
		idleCycles(1);
		waitDrain();
	endtask

	task automatic testExact();
		sendPair(makePair(16'h4200, 16'h4100));   // 3.0 x 2.5
		sendPair(makePair(16'hBC00, 16'h3800));   // -1.0 x 0.5
		sendPair(makePair(16'h4000, 16'h4400));
		idleCycles(2);                            // Gaps inside a row
		sendPair(makePair(16'h3E00, 16'h3E00));   // 1.5 squared
		sendPair(makePair(16'hC200, 16'hC200));
		sendPair(makePair(16'h7BFF, 16'h3C00));   // Max finite x 1
		flushTest();
	endtask

	task automatic testRounding();
		sendPair(makePair(16'h3C01, 16'h3E00));   // Tie with odd LSB rounds up
		sendPair(makePair(16'h3C03, 16'h3E00));   // Tie with even LSB stays
		sendPair(makePair(16'h3C01, 16'h3E01));   // Just above tie
		sendPair(makePair(16'h3C03, 16'h3DFF));   // Just below tie
		sendPair(makePair(16'h3C01, 16'h3C01));
		sendPair(makePair(16'h3DA8, 16'h3DA8));   // Carry bumps exponent
		sendPair(makePair(16'hBFFF, 16'h3C01));   // Product above 2
		sendPair(makePair(16'h4555, 16'hC555));
		flushTest();
	endtask

	task automatic testSpecials();
		sendPair(makePair(16'h7E00, 16'h3C00));   // NaN in
		sendPair(makePair(16'h7C01, 16'h0000));   // Signalling NaN x zero
		sendPair(makePair(16'h7C00, 16'hC000));   // -inf
		sendPair(makePair(16'hFC00, 16'h0000));   // Inf x zero
		sendPair(makePair(16'h0000, 16'h7C00));
		sendPair(makePair(16'h0200, 16'hFC00));   // Subnormal x inf
		sendPair(makePair(16'h8000, 16'h4000));   // -0
		sendPair(makePair(16'h0001, 16'h4000));   // Subnormal flushed
		sendPair(makePair(16'h3C00, 16'h8001));
		sendPair(makePair(16'hFC00, 16'hFC00));
		flushTest();
	endtask

	task automatic testRange();
		sendPair(makePair(16'h7BFF, 16'h7BFF));   // Overflow
		sendPair(makePair(16'h6000, 16'hE000));
		sendPair(makePair(16'h79A8, 16'h3DA8));   // Overflow from the round carry
		sendPair(makePair(16'h0400, 16'h0400));   // Underflow
		sendPair(makePair(16'h9000, 16'h1000));
		sendPair(makePair(16'h0400, 16'h3C00));   // Smallest normal stays exact
		sendPair(makePair(16'h0400, 16'h3BFF));   // Just under normal range
		sendPair(makePair(16'h7800, 16'h4000));   // 32768 x 2
		flushTest();
	endtask

	// Three rows with no idle cycle between pairs
	task automatic testStreaming();
		fpHalf x;
		fpHalf y;
		for (int i = 0; i < 3 * `VEC_LANES; i++) begin
			x.sign = i[0];
			x.exp = 5'd13 + 5'(i % 5);
			x.frac = 10'(i * 97);
			y.sign = i[1];
			y.exp = 5'd16 - 5'(i % 3);
			y.frac = 10'(i * 211 + 5);
			sendPair(makePair(x, y));
		end
		flushTest();
	endtask

	task automatic testRandom();
		for (int i = 0; i < 24 * `VEC_LANES; i++)
			sendPair(makePair(randomOperand(), randomOperand()));
		flushTest();
	endtask

	// Scoreboard samples on the falling edge where outputs are stable
	always @(negedge clk) begin
		if (!rst && outValid) begin
			if (expQ.size() == 0) begin
				stopWithFailure("DUT produced a result when none was expected");
			end else begin
				expRes = expQ.pop_front();
				compareHalf(outRes.prod, expRes.prod, $sformatf("result %0d", checkedCount));
				compareFlags(outRes.flags, expRes.flags, $sformatf("result %0d", checkedCount));
				checkedCount++;
			end
		end else if (!rst && checkedCount % `VEC_LANES != 0) begin
			stopWithFailure("output strobe dropped in the middle of a row");
		end
	end

	// Budget grows with every row sent
	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * rowsSent + 200)
			stopWithFailure("timeout: results did not drain in time");
	end

	initial begin
		rst = 1'b1;
		inValid = 1'b0;
		inPair = '0;
		repeat (10) @(posedge clk);   // Ten reset cycles
		@(negedge clk);
		rst = 1'b0;
		testExact();
		testRounding();
		testSpecials();
		testRange();
		testStreaming();
		testRandom();
		idleCycles(2 * `VEC_LANES);   // Catch stray strobes
		if (checkedCount != pairCount) begin
			stopWithFailure("some results never came out of the DUT");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule
